//--- ecc_111_cal.f
hdl/ecc_code_pkg.sv
hdl/ecc_status_pkg.sv
hdl/ecc_encoder.sv
hdl/ecc_decoder.sv
hdl/ecc_111_cal.sv
verification/ecc_111_cal_assert.sv
verification/ecc_111_cal_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := ecc_111_cal_tb
FILELIST   := ecc_111_cal.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Mdir $(OBJ_DIR)
SIM_ARGS   := +verilator+error+limit+100
PASS_MSG   := NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build, run, and pass only if the pass line shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verification/ecc_111_cal_tb.sv
`timescale 1ns/1ps

module ecc_111_cal_tb;

    import ecc_code_pkg::*;

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 8;
    localparam int N_CLEAN        = 40;
    localparam int N_DOUBLE       = 150;
    localparam int N_BYPASS       = 40;
    localparam int CODE_WIDTH     = DATA_WIDTH + CHECK_WIDTH;
    // 8 reset cycles and 349 vectors, with generous margin
    localparam int TIMEOUT_CYCLES = 1000;

    typedef logic [CODE_WIDTH-1:0] codeword_t;

    logic        clk = 1'b0;
    logic        rst_n;
    data_word_t  data_in;
    check_word_t parity_in;
    logic        bypass;
    data_word_t  data_out;
    check_word_t parity_out;
    logic        sbit_err;
    logic        dbit_err;
    int          seed = 32'hd137_74f9;
    int          cycle_count = 0;

    ecc_111_cal dut (
        .data_in    (data_in),
        .parity_in  (parity_in),
        .bypass     (bypass),
        .data_out   (data_out),
        .parity_out (parity_out),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    // Checker rides on the DUT, clock and reset come from here
    bind ecc_111_cal ecc_111_cal_assert u_assert (
        .clk        (ecc_111_cal_tb.clk),
        .rst_n      (ecc_111_cal_tb.rst_n),
        .data_in    (data_in),
        .parity_in  (parity_in),
        .bypass     (bypass),
        .data_out   (data_out),
        .parity_out (parity_out),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("ERRORS FOUND");
        $fatal(1, "%s", why);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (dut.u_assert.err_flag) begin
            stop_with_failure("a DUT output assertion failed");
        end else if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("timeout, run still going after %0d cycles",
                                        TIMEOUT_CYCLES));
        end
    end

    // Check bit k per data bit, positions counted past the powers of two
    function automatic check_word_t encode(input data_word_t d);
        check_word_t c;
        int          pos;
        c   = '0;
        pos = 2;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            pos = pos + 1;
            if ((pos & (pos - 1)) == 0) begin
                pos = pos + 1;
            end
            for (int k = 0; k < CHECK_WIDTH - 1; k++) begin
                c[k] = c[k] ^ (d[i] & pos[k]);
            end
        end
        c[CHECK_WIDTH-1] = ^{d, c[CHECK_WIDTH-2:0]};
        return c;
    endfunction

    function automatic data_word_t random_word();
        logic [127:0] r;
        r = {$random(seed), $random(seed), $random(seed), $random(seed)};
        return r[DATA_WIDTH-1:0];
    endfunction

    function automatic int random_index(input int limit);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(limit));
    endfunction

    task automatic apply_vector(input data_word_t d, input check_word_t p, input logic byp);
        @(negedge clk);
        data_in   = d;
        parity_in = p;
        bypass    = byp;
    endtask

    // Codeword bit index, -1 leaves it alone; check bits sit above the data
    task automatic send_with_flips(input data_word_t d, input int flip_a, input int flip_b,
                                   input logic byp);
        codeword_t cw;
        cw = {encode(d), d};
        if (flip_a >= 0) begin
            cw = cw ^ (codeword_t'(1) << flip_a);
        end
        if (flip_b >= 0) begin
            cw = cw ^ (codeword_t'(1) << flip_b);
        end
        apply_vector(cw[DATA_WIDTH-1:0], cw[CODE_WIDTH-1:DATA_WIDTH], byp);
    endtask

    initial begin : stimulus
        int a;
        int b;
        rst_n     = 1'b0;
        data_in   = '0;
        parity_in = '0;
        bypass    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        repeat (N_CLEAN) begin
            send_with_flips(random_word(), -1, -1, 1'b0);
        end
        for (int i = 0; i < DATA_WIDTH; i++) begin
            send_with_flips(random_word(), i, -1, 1'b0);
        end
        // Check bit 7 alone gives the bare top-bit syndrome
        for (int k = 0; k < CHECK_WIDTH; k++) begin
            send_with_flips(random_word(), DATA_WIDTH + k, -1, 1'b0);
        end
        repeat (N_DOUBLE) begin
            a = random_index(CODE_WIDTH);
            b = random_index(CODE_WIDTH - 1);
            if (b >= a) begin
                b = b + 1;
            end
            send_with_flips(random_word(), a, b, 1'b0);
        end
        // Bypass, mixing clean, single and double corruption
        for (int n = 0; n < N_BYPASS; n++) begin
            a = (n % 3 == 0) ? -1 : random_index(CODE_WIDTH);
            b = (n % 3 == 2) ? (a + 1) % CODE_WIDTH : -1;
            send_with_flips(random_word(), a, b, 1'b1);
        end

        @(negedge clk);
        @(negedge clk);
        if (dut.u_assert.err_flag) begin
            stop_with_failure("a DUT output assertion failed");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

//--- verification/ecc_111_cal_assert.sv
`timescale 1ns/1ps

module ecc_111_cal_assert (
    input logic                      clk,
    input logic                      rst_n,
    input ecc_code_pkg::data_word_t  data_in,
    input ecc_code_pkg::check_word_t parity_in,
    input logic                      bypass,
    input ecc_code_pkg::data_word_t  data_out,
    input ecc_code_pkg::check_word_t parity_out,
    input logic                      sbit_err,
    input logic                      dbit_err
);

    import ecc_code_pkg::*;
    import ecc_status_pkg::*;

    check_word_t exp_parity;
    syndrome_t   syn;
    int          flip_idx;
    data_word_t  exp_data;
    ecc_status_t exp_status;
    logic        fail_parity = 1'b0;
    logic        fail_data   = 1'b0;
    logic        fail_sbit   = 1'b0;
    logic        fail_dbit   = 1'b0;
    logic        fail_excl   = 1'b0;
    logic        err_flag;

    // Walks the Hamming positions, skipping each power of two
    function automatic check_word_t ref_check(input data_word_t d);
        check_word_t c;
        int          pos;
        c   = '0;
        pos = 2;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            pos = pos + 1;
            if ((pos & (pos - 1)) == 0) begin
                pos = pos + 1;
            end
            for (int k = 0; k < POS_WIDTH; k++) begin
                if (pos[k]) begin
                    c[k] = c[k] ^ d[i];
                end
            end
        end
        c[POS_WIDTH] = (^d) ^ (^c[POS_WIDTH-1:0]);
        return c;
    endfunction

    // Data bit sitting at Hamming position target, -1 when none does
    function automatic int ref_data_index(input int target);
        int pos;
        int found;
        pos   = 2;
        found = -1;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            pos = pos + 1;
            if ((pos & (pos - 1)) == 0) begin
                pos = pos + 1;
            end
            if (pos == target) begin
                found = i;
            end
        end
        return found;
    endfunction

    always_comb begin
        exp_parity = ref_check(data_in);
        syn        = parity_in ^ exp_parity;
        flip_idx   = ref_data_index(int'(syn[POS_WIDTH-1:0]));
        exp_data   = data_in;
        exp_status = '0;
        if (bypass || syn == '0) begin
            exp_status = '0;
        end else if ((^syn) && flip_idx >= 0) begin
            // Odd overall parity pointing at a data bit
            for (int i = 0; i < DATA_WIDTH; i++) begin
                if (i == flip_idx) begin
                    exp_data[i] = ~exp_data[i];
                end
            end
            exp_status.sbit_err = 1'b1;
        end else if ($countones(syn) == 1) begin
            exp_status.sbit_err = 1'b1;
        end else begin
            exp_status.dbit_err = 1'b1;
        end
    end

    parity_ok: assert property (@(posedge clk) disable iff (!rst_n)
        parity_out == exp_parity)
        else begin
            $error("MISMATCH parity_out expected %h got %h", exp_parity, parity_out);
            fail_parity = 1'b1;
        end

    data_ok: assert property (@(posedge clk) disable iff (!rst_n)
        data_out == exp_data)
        else begin
            $error("MISMATCH data_out expected %h got %h", exp_data, data_out);
            fail_data = 1'b1;
        end

    sbit_ok: assert property (@(posedge clk) disable iff (!rst_n)
        sbit_err == exp_status.sbit_err)
        else begin
            $error("MISMATCH sbit_err expected %h got %h", exp_status.sbit_err, sbit_err);
            fail_sbit = 1'b1;
        end

    dbit_ok: assert property (@(posedge clk) disable iff (!rst_n)
        dbit_err == exp_status.dbit_err)
        else begin
            $error("MISMATCH dbit_err expected %h got %h", exp_status.dbit_err, dbit_err);
            fail_dbit = 1'b1;
        end

    flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(sbit_err && dbit_err))
        else begin
            $error("MISMATCH sbit_err and dbit_err expected not both 1, got %h and %h",
                   sbit_err, dbit_err);
            fail_excl = 1'b1;
        end

    assign err_flag = fail_parity | fail_data | fail_sbit | fail_dbit | fail_excl;

endmodule

//--- hdl/ecc_111_cal.sv
`timescale 1ns/1ps

module ecc_111_cal (
    input  ecc_code_pkg::data_word_t  data_in,
    input  ecc_code_pkg::check_word_t parity_in,
    input  logic                      bypass,
    output ecc_code_pkg::data_word_t  data_out,
    output ecc_code_pkg::check_word_t parity_out,
    output logic                      sbit_err,
    output logic                      dbit_err
);

    import ecc_status_pkg::*;

    ecc_status_t status;

    // Check word of the incoming data, also the decoder reference
    ecc_encoder u_encoder (
        .data  (data_in),
        .check (parity_out)
    );

    ecc_decoder u_decoder (
        .data_in     (data_in),
        .parity_in   (parity_in),
        .parity_calc (parity_out),
        .bypass      (bypass),
        .data_out    (data_out),
        .status      (status)
    );

    assign sbit_err = status.sbit_err;
    assign dbit_err = status.dbit_err;

endmodule

//--- hdl/ecc_decoder.sv
`timescale 1ns/1ps

module ecc_decoder (
    input  ecc_code_pkg::data_word_t    data_in,
    input  ecc_code_pkg::check_word_t   parity_in,
    input  ecc_code_pkg::check_word_t   parity_calc,
    input  logic                        bypass,
    output ecc_code_pkg::data_word_t    data_out,
    output ecc_status_pkg::ecc_status_t status
);

    import ecc_code_pkg::*;
    import ecc_status_pkg::*;

    syndrome_t    syndrome;
    hamming_pos_t syn_pos;
    logic         odd_parity;
    logic         check_hit;
    logic         data_hit;
    data_word_t   pos_mask;
    ecc_fix_t     fix;

    assign syndrome = parity_in ^ parity_calc;
    assign syn_pos  = syndrome[POS_WIDTH-1:0];

    // Overall parity of the received word
    // Any single flipped bit makes it odd, two flipped bits keep it even
    assign odd_parity = ^syndrome;

    // Lone syndrome bit means the flip sits in the check word itself
    assign check_hit = $onehot(syndrome);

    // One-hot decode of the Hamming position onto the data bits
    always_comb begin
        pos_mask = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            if (data_position(i) == syn_pos) begin
                pos_mask[i] = 1'b1;
            end
        end
    end

    assign data_hit = |pos_mask;

    // Syndrome classification
    //   zero                         no error
    //   odd, position of a data bit  single data error, flip it back
    //   exactly one bit set          single check error, data untouched
    //   anything else                double error
    always_comb begin
        fix = '0;
        if (syndrome == '0) begin
            fix.status = '0;
        end else if (odd_parity && data_hit) begin
            fix.mask            = pos_mask;
            fix.status.sbit_err = 1'b1;
        end else if (check_hit) begin
            fix.status.sbit_err = 1'b1;
        end else begin
            fix.status.dbit_err = 1'b1;
        end
    end

    // Correction, bypass passes data as received with flags cleared
    always_comb begin
        if (bypass) begin
            data_out = data_in;
            status   = '0;
        end else begin
            data_out = data_in ^ fix.mask;
            status   = fix.status;
        end
    end

endmodule

//--- hdl/ecc_encoder.sv
`timescale 1ns/1ps

module ecc_encoder (
    input  ecc_code_pkg::data_word_t  data,
    output ecc_code_pkg::check_word_t check
);

    import ecc_code_pkg::*;

    // Hamming part of the check word
    hamming_pos_t ham;

    // Check bit k covers every data bit whose position has bit k set
    always_comb begin : hamming_bits
        hamming_pos_t pos;
        ham = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            pos = data_position(i);
            for (int k = 0; k < POS_WIDTH; k++) begin
                ham[k] = ham[k] ^ (data[i] & pos[k]);
            end
        end
    end

    // Top bit is overall parity of the data and the seven Hamming bits
    assign check = {(^data) ^ (^ham), ham};

endmodule

//--- hdl/ecc_status_pkg.sv
package ecc_status_pkg;

    // Decoder error flags, at most one of them high
    typedef struct packed {
        logic sbit_err;
        logic dbit_err;
    } ecc_status_t;

    // Result of syndrome classification
    // mask is one-hot on a correctable data bit, zero otherwise
    typedef struct packed {
        ecc_code_pkg::data_word_t mask;
        ecc_status_t              status;
    } ecc_fix_t;

endpackage

//--- hdl/ecc_code_pkg.sv
package ecc_code_pkg;

    // Data bits protected by the code
    localparam int DATA_WIDTH  = 111;

    // Seven Hamming check bits plus one overall parity bit
    localparam int CHECK_WIDTH = 8;

    // Width of a Hamming position, positions 1 to 127
    localparam int POS_WIDTH   = CHECK_WIDTH - 1;

    typedef logic [DATA_WIDTH-1:0]  data_word_t;
    typedef logic [CHECK_WIDTH-1:0] check_word_t;
    typedef logic [CHECK_WIDTH-1:0] syndrome_t;
    typedef logic [POS_WIDTH-1:0]   hamming_pos_t;

    // Hamming position of data bit idx, counting from 1
    //
    // Data bits fill the positions that are not powers of two, so
    // data bit 0 lands on 3 and data bit 110 on 118. Positions 1 and 2
    // are skipped up front, then each higher power of two that the
    // running position reaches pushes it up by one.
    function automatic hamming_pos_t data_position(input int unsigned idx);
        int unsigned pos;
        pos = idx + 3;
        for (int k = 2; k < POS_WIDTH; k++) begin
            if (pos >= (32'd1 << k)) begin
                pos = pos + 1;
            end
        end
        return hamming_pos_t'(pos);
    endfunction

endpackage
